//--- list.f
+incdir+test
logic/ctrl_pkg.sv
logic/ctrl_event_if.sv
logic/ctrl_event_decode.sv
logic/fencei_handshake.sv
logic/pipe_ctrl_fsm.sv
logic/pipe_ctrl_top.sv
test/pipe_ctrl_tb.sv

//--- Makefile
# Verilator build for the pipeline controller testbench

VERILATOR ?= verilator
TOP       ?= pipe_ctrl_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- test/pipe_ctrl_tests.svh
////////////////////////////////////////
// Pipeline controller directed tests
// Boot, traps, redirects, sleep, fence.i
////////////////////////////////////////
`ifndef PIPE_CTRL_TESTS_SVH
`define PIPE_CTRL_TESTS_SVH

task automatic boot_sequence();
  int err0;
  err0 = errors;
  @(negedge clk);
  expect_eq("instr_req_o", 32'(instr_req_o), 32'd0);
  expect_eq("pc_set_o", 32'(pc_set_o), 32'd0);
  expect_eq("busy_o", 32'(busy_o), 32'd1);
  @(posedge clk);
  fetch_enable_i <= 1'b1;
  wait_pc_set(8);
  expect_eq("pc_mux_o", 32'(pc_mux_o), 32'(PC_BOOT));
  expect_eq("busy_o", 32'(busy_o), 32'd1);
  // Single cycle pulse, then fetching
  @(negedge clk);
  expect_eq("pc_set_o", 32'(pc_set_o), 32'd0);
  expect_eq("instr_req_o", 32'(instr_req_o), 32'd1);
  finish_test("boot", err0);
endtask

task automatic exception_causes();
  int          err0;
  int          i;
  logic [31:0] rnd;
  logic [4:0]  flags;
  mpu_status_e mpu;
  err0 = errors;
  for (i = 0; i < 16; i++) begin
    rnd   = $urandom();
    // Two masks ANDed give sparser flag sets
    flags = rnd[4:0] & rnd[9:5];
    case (rnd[11:10])
      2'd1:    mpu = MPU_RE_FAULT;
      2'd2:    mpu = MPU_WR_FAULT;
      default: mpu = MPU_OK;
    endcase
    if (flags == '0 && mpu == MPU_OK) begin
      flags = 5'b00100;
    end
    @(posedge clk);
    drive_idle();
    wb_instr_valid_i   <= 1'b1;
    wb_instr_fault_i   <= flags[0];
    wb_instr_bus_err_i <= flags[1];
    wb_illegal_i       <= flags[2];
    wb_ecall_i         <= flags[3];
    wb_ebreak_i        <= flags[4];
    wb_mpu_status_i    <= mpu;
    @(negedge clk);
    expect_eq("pc_set_o", 32'(pc_set_o), 32'd1);
    expect_eq("pc_mux_o", 32'(pc_mux_o), 32'(PC_EXCEPTION));
    expect_eq("exc_pc_mux_o", 32'(exc_pc_mux_o), 32'(EXC_PC_EXCEPTION));
    expect_eq("kill_o", 32'(kill_o), 32'b0111);
    expect_eq("csr_save_o", 32'(csr_save_o), 32'b1000);
    expect_eq("csr_save_cause_o", 32'(csr_save_cause_o), 32'd1);
    expect_eq("csr_cause_o", 32'(csr_cause_o), 32'(expected_cause(flags, mpu)));
  end
  @(posedge clk);
  drive_idle();
  finish_test("exceptions", err0);
endtask

task automatic interrupt_entry();
  int          err0;
  logic [31:0] rnd;
  irq_id_t     id;
  err0 = errors;
  rnd  = $urandom();
  id   = rnd[4:0];
  // Id zero would look the same in both mtvec modes
  if (id == '0) begin
    id = 5'd1;
  end
  // Vectored mode, oldest valid instruction sits in EX
  @(posedge clk);
  irq_req_i        <= 1'b1;
  irq_id_i         <= id;
  mtvec_mode_i     <= MTVEC_VECTORED;
  id_instr_valid_i <= 1'b1;
  ex_instr_valid_i <= 1'b1;
  @(negedge clk);
  expect_eq("irq_ack_o", 32'(irq_ack_o), 32'd1);
  expect_eq("irq_id_o", 32'(irq_id_o), 32'(id));
  expect_eq("kill_o", 32'(kill_o), 32'b1111);
  expect_eq("exc_pc_mux_o", 32'(exc_pc_mux_o), 32'(EXC_PC_IRQ));
  expect_eq("csr_save_cause_o", 32'(csr_save_cause_o), 32'd1);
  expect_eq("csr_cause_irq_o", 32'(csr_cause_irq_o), 32'd1);
  expect_eq("csr_cause_o", 32'(csr_cause_o), 32'(id));
  expect_eq("csr_save_o", 32'(csr_save_o), 32'b0100);
  expect_eq("exc_vec_idx_o", 32'(exc_vec_idx_o), 32'(id));
  // Direct mode always enters at index zero
  @(posedge clk);
  mtvec_mode_i <= 2'b00;
  @(negedge clk);
  expect_eq("irq_ack_o", 32'(irq_ack_o), 32'd1);
  expect_eq("exc_vec_idx_o", 32'(exc_vec_idx_o), 32'd0);
  // LSU instruction in WB blocks the interrupt and stalls ID
  @(posedge clk);
  wb_instr_valid_i <= 1'b1;
  wb_lsu_en_i      <= 1'b1;
  @(negedge clk);
  expect_eq("irq_ack_o", 32'(irq_ack_o), 32'd0);
  expect_eq("halt_o", 32'(halt_o), 32'b0010);
  expect_eq("pc_set_o", 32'(pc_set_o), 32'd0);
  @(posedge clk);
  drive_idle();
  finish_test("interrupts", err0);
endtask

task automatic redirect_once();
  int err0;
  err0 = errors;
  @(posedge clk);
  ex_instr_valid_i  <= 1'b1;
  ex_branch_taken_i <= 1'b1;
  @(negedge clk);
  expect_eq("pc_set_o", 32'(pc_set_o), 32'd1);
  expect_eq("pc_mux_o", 32'(pc_mux_o), 32'(PC_BRANCH));
  expect_eq("kill_o", 32'(kill_o), 32'b0011);
  // Held branch stays blocked until the handshake clears the flag
  @(posedge clk);
  if_valid_i <= 1'b1;
  @(negedge clk);
  expect_eq("pc_set_o", 32'(pc_set_o), 32'd0);
  // Jump held in ID
  @(posedge clk);
  drive_idle();
  id_instr_valid_i <= 1'b1;
  id_jump_i        <= 1'b1;
  @(negedge clk);
  expect_eq("pc_set_o", 32'(pc_set_o), 32'd1);
  expect_eq("pc_mux_o", 32'(pc_mux_o), 32'(PC_JUMP));
  expect_eq("kill_o", 32'(kill_o), 32'b0001);
  repeat (3) begin
    @(negedge clk);
    expect_eq("pc_set_o", 32'(pc_set_o), 32'd0);
  end
  @(posedge clk);
  if_valid_i <= 1'b1;
  @(negedge clk);
  expect_eq("pc_set_o", 32'(pc_set_o), 32'd0);
  @(posedge clk);
  if_valid_i <= 1'b0;
  @(negedge clk);
  expect_eq("pc_set_o", 32'(pc_set_o), 32'd1);
  expect_eq("pc_mux_o", 32'(pc_mux_o), 32'(PC_JUMP));
  // mret in ID, once the previous redirect is cleared
  @(posedge clk);
  id_jump_i  <= 1'b0;
  id_mret_i  <= 1'b1;
  if_valid_i <= 1'b1;
  @(negedge clk);
  expect_eq("pc_set_o", 32'(pc_set_o), 32'd0);
  @(posedge clk);
  if_valid_i <= 1'b0;
  @(negedge clk);
  expect_eq("pc_set_o", 32'(pc_set_o), 32'd1);
  expect_eq("pc_mux_o", 32'(pc_mux_o), 32'(PC_MRET));
  // mret reaching WB restores the CSRs
  @(posedge clk);
  drive_idle();
  if_valid_i       <= 1'b1;
  wb_instr_valid_i <= 1'b1;
  wb_mret_i        <= 1'b1;
  @(negedge clk);
  expect_eq("csr_restore_mret_o", 32'(csr_restore_mret_o), 32'd1);
  @(posedge clk);
  drive_idle();
  finish_test("redirect", err0);
endtask

task automatic wfi_sleep();
  int err0;
  err0 = errors;
  @(posedge clk);
  wb_instr_valid_i <= 1'b1;
  wb_wfi_i         <= 1'b1;
  @(negedge clk);
  expect_eq("halt_o", 32'(halt_o), 32'b0011);
  expect_eq("instr_req_o", 32'(instr_req_o), 32'd0);
  @(posedge clk);
  drive_idle();
  repeat (2) begin
    @(negedge clk);
    expect_eq("busy_o", 32'(busy_o), 32'd0);
    expect_eq("instr_req_o", 32'(instr_req_o), 32'd0);
    expect_eq("halt_o", 32'(halt_o), 32'b1000);
  end
  @(posedge clk);
  irq_wakeup_i <= 1'b1;
  @(negedge clk);
  expect_eq("busy_o", 32'(busy_o), 32'd0);
  @(posedge clk);
  irq_wakeup_i <= 1'b0;
  @(negedge clk);
  expect_eq("busy_o", 32'(busy_o), 32'd1);
  expect_eq("instr_req_o", 32'(instr_req_o), 32'd1);
  finish_test("wfi", err0);
endtask

task automatic fencei_flush();
  int          err0;
  int          delay;
  logic [31:0] rnd;
  err0  = errors;
  rnd   = $urandom();
  delay = 1 + int'(rnd[2:0]);
  @(posedge clk);
  wb_instr_valid_i <= 1'b1;
  wb_fencei_i      <= 1'b1;
  @(negedge clk);
  expect_eq("kill_o", 32'(kill_o), 32'b0111);
  expect_eq("halt_o", 32'(halt_o), 32'b1000);
  expect_eq("pc_set_o", 32'(pc_set_o), 32'd0);
  wait_flush_req(8);
  // Request holds while the acknowledge is late
  repeat (delay) begin
    @(negedge clk);
    expect_eq("fencei_flush_req_o", 32'(fencei_flush_req_o), 32'd1);
    expect_eq("pc_set_o", 32'(pc_set_o), 32'd0);
  end
  @(posedge clk);
  fencei_flush_ack_i <= 1'b1;
  @(negedge clk);
  expect_eq("pc_set_o", 32'(pc_set_o), 32'd0);
  @(posedge clk);
  fencei_flush_ack_i <= 1'b0;
  wait_pc_set(8);
  expect_eq("pc_mux_o", 32'(pc_mux_o), 32'(PC_FENCEI));
  expect_eq("halt_o", 32'(halt_o), 32'b0000);
  expect_eq("fencei_flush_req_o", 32'(fencei_flush_req_o), 32'd0);
  @(posedge clk);
  drive_idle();
  finish_test("fencei", err0);
endtask

`endif

//--- test/pipe_ctrl_tb.sv
////////////////////////////////////////
// Pipeline controller testbench
// Clock, reset, DUT, watchdog, checks,
// expected-value models and reporting
////////////////////////////////////////
`timescale 1ns/1ns

module pipe_ctrl_tb import ctrl_pkg::*; ();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  localparam int N_TESTS      = 6;
  localparam int CYCLE_BUDGET = 120;
  localparam int WATCHDOG_NS  = (N_TESTS * CYCLE_BUDGET + RESET_CYCLES) * CLK_PERIOD;

  logic        clk;
  logic        rst_n;
  logic        fetch_enable_i;
  // Stage handshakes
  logic        if_valid_i, id_ready_i, ex_valid_i, wb_ready_i;
  // ID stage
  logic        id_instr_valid_i, id_jump_i, id_mret_i;
  logic        jr_stall_i, csr_stall_i, load_stall_i;
  // EX stage
  logic        ex_instr_valid_i, ex_branch_taken_i, data_req_i;
  // WB stage
  logic        wb_instr_valid_i, wb_lsu_en_i, wb_instr_fault_i, wb_instr_bus_err_i;
  logic        wb_illegal_i, wb_ecall_i, wb_ebreak_i, wb_wfi_i, wb_fencei_i, wb_mret_i;
  mpu_status_e wb_mpu_status_i;
  // Interrupts and fence.i
  logic        irq_req_i, irq_wakeup_i, irq_ack_o;
  irq_id_t     irq_id_i, irq_id_o;
  logic [1:0]  mtvec_mode_i;
  logic        fencei_flush_req_o, fencei_flush_ack_i;
  // Controller outputs
  logic        instr_req_o, busy_o, pc_set_o;
  pc_mux_e     pc_mux_o;
  exc_pc_mux_e exc_pc_mux_o;
  irq_id_t     exc_vec_idx_o;
  stage_mask_t halt_o, kill_o, csr_save_o;
  logic        csr_save_cause_o, csr_cause_irq_o, csr_restore_mret_o;
  exc_code_t   csr_cause_o;

  int checks;
  int errors;
  int tests_run;
  int tests_failed;

  pipe_ctrl_top dut (.*);

  initial begin
    clk = 1'b0;
  end

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////
  // Checks and reporting
  //////////////////////////////////////
  task automatic expect_eq(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %-10s ok", name);
    end else begin
      tests_failed++;
      $display("test %-10s %0d errors", name, errors - err_before);
    end
  endtask

  // Highest priority cause of a faulting WB instruction
  function automatic exc_code_t expected_cause(input logic [4:0] flags,
                                               input mpu_status_e mpu);
    // flags: 0 fetch fault, 1 fetch bus error, 2 illegal, 3 ecall, 4 ebreak
    if (flags[0]) return EXC_CAUSE_INSTR_FAULT;
    if (flags[1]) return EXC_CAUSE_INSTR_BUS_FAULT;
    if (flags[2]) return EXC_CAUSE_ILLEGAL_INSN;
    if (flags[3]) return EXC_CAUSE_ECALL_MMODE;
    if (flags[4]) return EXC_CAUSE_BREAKPOINT;
    if (mpu == MPU_WR_FAULT) return EXC_CAUSE_STORE_FAULT;
    if (mpu == MPU_RE_FAULT) return EXC_CAUSE_LOAD_FAULT;
    return '0;
  endfunction

  // Quiet pipeline, called right after a rising edge
  task automatic drive_idle();
    if_valid_i         <= 1'b0;
    id_ready_i         <= 1'b1;
    ex_valid_i         <= 1'b0;
    wb_ready_i         <= 1'b1;
    id_instr_valid_i   <= 1'b0;
    id_jump_i          <= 1'b0;
    id_mret_i          <= 1'b0;
    jr_stall_i         <= 1'b0;
    csr_stall_i        <= 1'b0;
    load_stall_i       <= 1'b0;
    ex_instr_valid_i   <= 1'b0;
    ex_branch_taken_i  <= 1'b0;
    data_req_i         <= 1'b0;
    wb_instr_valid_i   <= 1'b0;
    wb_lsu_en_i        <= 1'b0;
    wb_instr_fault_i   <= 1'b0;
    wb_instr_bus_err_i <= 1'b0;
    wb_illegal_i       <= 1'b0;
    wb_ecall_i         <= 1'b0;
    wb_ebreak_i        <= 1'b0;
    wb_wfi_i           <= 1'b0;
    wb_fencei_i        <= 1'b0;
    wb_mret_i          <= 1'b0;
    wb_mpu_status_i    <= MPU_OK;
    irq_req_i          <= 1'b0;
    irq_id_i           <= '0;
    irq_wakeup_i       <= 1'b0;
    mtvec_mode_i       <= 2'b00;
    fencei_flush_ack_i <= 1'b0;
  endtask

  // Sample at falling edges until pc_set_o rises
  task automatic wait_pc_set(input int max_cycles);
    int n;
    n = 0;
    @(negedge clk);
    while (!pc_set_o && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (!pc_set_o) begin
      $display("ERROR at %0t ns: pc_set_o did not rise within %0d cycles", $time, max_cycles);
      errors++;
    end
  endtask

  task automatic wait_flush_req(input int max_cycles);
    int n;
    n = 0;
    @(negedge clk);
    while (!fencei_flush_req_o && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (!fencei_flush_req_o) begin
      $display("ERROR at %0t ns: fence.i flush request never appeared", $time);
      errors++;
    end
  endtask

  `include "pipe_ctrl_tests.svh"

  //////////////////////////////////////
  // Main sequence
  //////////////////////////////////////
  initial begin
    checks       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(32'h90fa));
    rst_n          = 1'b0;
    fetch_enable_i <= 1'b0;
    drive_idle();
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    boot_sequence();
    exception_causes();
    interrupt_entry();
    redirect_once();
    wfi_sleep();
    fencei_flush();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Stops a run that hangs in a wait
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
    $display("Regression failed");
    $finish;
  end

endmodule

//--- logic/pipe_ctrl_top.sv
////////////////////////////////////////
// Pipeline controller top level
// Event decoder, fence.i handshake and
// controller FSM
////////////////////////////////////////
`timescale 1ns/1ns

module pipe_ctrl_top import ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fetch_enable_i,
  // Stage handshakes
  input  logic        if_valid_i,
  input  logic        id_ready_i,
  input  logic        ex_valid_i,
  input  logic        wb_ready_i,
  // ID stage
  input  logic        id_instr_valid_i,
  input  logic        id_jump_i,
  input  logic        id_mret_i,
  input  logic        jr_stall_i,
  input  logic        csr_stall_i,
  input  logic        load_stall_i,
  // EX stage
  input  logic        ex_instr_valid_i,
  input  logic        ex_branch_taken_i,
  input  logic        data_req_i,
  // WB stage
  input  logic        wb_instr_valid_i,
  input  logic        wb_lsu_en_i,
  input  logic        wb_instr_fault_i,
  input  logic        wb_instr_bus_err_i,
  input  logic        wb_illegal_i,
  input  logic        wb_ecall_i,
  input  logic        wb_ebreak_i,
  input  logic        wb_wfi_i,
  input  logic        wb_fencei_i,
  input  logic        wb_mret_i,
  input  mpu_status_e wb_mpu_status_i,
  // Interrupts
  input  logic        irq_req_i,
  input  irq_id_t     irq_id_i,
  input  logic        irq_wakeup_i,
  input  logic [1:0]  mtvec_mode_i,
  output logic        irq_ack_o,
  output irq_id_t     irq_id_o,
  // fence.i flush
  output logic        fencei_flush_req_o,
  input  logic        fencei_flush_ack_i,
  // Fetch and PC control
  output logic        instr_req_o,
  output logic        busy_o,
  output logic        pc_set_o,
  output pc_mux_e     pc_mux_o,
  output exc_pc_mux_e exc_pc_mux_o,
  output irq_id_t     exc_vec_idx_o,
  // Stage control and CSR updates
  output stage_mask_t halt_o,
  output stage_mask_t kill_o,
  output stage_mask_t csr_save_o,
  output logic        csr_save_cause_o,
  output exc_code_t   csr_cause_o,
  output logic        csr_cause_irq_o,
  output logic        csr_restore_mret_o
);

  logic fencei_start;
  logic fencei_done;
  logic fencei_ongoing;
  logic branch_taken_q;

  ctrl_event_if ev ();

  ctrl_event_decode u_decode (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .fencei_ongoing_i (fencei_ongoing),
    .branch_taken_q_i (branch_taken_q),
    .ev               (ev.decoder),
    .*
  );

  fencei_handshake u_fencei (
    .flush_start_i (fencei_start),
    .done_o        (fencei_done),
    .ongoing_o     (fencei_ongoing),
    .*
  );

  pipe_ctrl_fsm u_fsm (
    .ev               (ev.fsm),
    .fencei_done_i    (fencei_done),
    .fencei_start_o   (fencei_start),
    .branch_taken_q_o (branch_taken_q),
    .*
  );

endmodule

//--- logic/pipe_ctrl_fsm.sv
////////////////////////////////////////
// Pipeline controller FSM
// Boot sequencing, PC redirects, traps,
// sleep and per-stage halt/kill/save
////////////////////////////////////////
`timescale 1ns/1ns

module pipe_ctrl_fsm import ctrl_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         fetch_enable_i,
  input  logic         if_valid_i,
  input  logic         id_ready_i,
  input  logic         id_instr_valid_i,
  input  logic         ex_instr_valid_i,
  input  logic         wb_instr_valid_i,
  input  logic         irq_req_i,
  input  logic         irq_wakeup_i,
  input  irq_id_t      irq_id_i,
  input  logic [1:0]   mtvec_mode_i,
  ctrl_event_if.fsm    ev,
  input  logic         fencei_done_i,
  output logic         fencei_start_o,
  output logic         instr_req_o,
  output logic         busy_o,
  output logic         pc_set_o,
  output pc_mux_e      pc_mux_o,
  output exc_pc_mux_e  exc_pc_mux_o,
  output irq_id_t      exc_vec_idx_o,
  output stage_mask_t  halt_o,
  output stage_mask_t  kill_o,
  output stage_mask_t  csr_save_o,
  output logic         csr_save_cause_o,
  output exc_code_t    csr_cause_o,
  output logic         csr_cause_irq_o,
  output logic         csr_restore_mret_o,
  output logic         irq_ack_o,
  output irq_id_t      irq_id_o,
  output logic         branch_taken_q_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_n;
  logic        branch_taken_q;
  logic        branch_taken_n;
  logic        irq_take;
  stage_mask_t trap_save;

  assign irq_take         = irq_req_i && ev.irq_allowed;
  assign branch_taken_q_o = branch_taken_q;

  // Handler index only used in vectored mode
  assign exc_vec_idx_o = (mtvec_mode_i == MTVEC_VECTORED) ? irq_id_i : '0;

  // PC of the oldest valid instruction, IF always holds a valid PC
  always_comb begin
    trap_save = '0;
    if (wb_instr_valid_i) begin
      trap_save[STAGE_WB] = 1'b1;
    end else if (ex_instr_valid_i) begin
      trap_save[STAGE_EX] = 1'b1;
    end else if (id_instr_valid_i) begin
      trap_save[STAGE_ID] = 1'b1;
    end else begin
      trap_save[STAGE_IF] = 1'b1;
    end
  end

  //////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////
  always_comb begin
    state_n            = state_q;
    busy_o             = 1'b1;
    instr_req_o        = 1'b1;
    pc_set_o           = 1'b0;
    pc_mux_o           = PC_BOOT;
    exc_pc_mux_o       = EXC_PC_IRQ;
    // ID waits on stalls and on an interrupt it may not take yet
    halt_o             = '0;
    halt_o[STAGE_ID]   = ev.stall_id || (irq_req_i && !ev.irq_allowed);
    kill_o             = '0;
    csr_save_o         = '0;
    csr_save_cause_o   = 1'b0;
    csr_cause_o        = '0;
    csr_cause_irq_o    = 1'b0;
    csr_restore_mret_o = 1'b0;
    irq_ack_o          = 1'b0;
    irq_id_o           = '0;
    fencei_start_o     = 1'b0;
    branch_taken_n     = branch_taken_q;

    unique case (state_q)
      RESET: begin
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_n = BOOT_SET;
        end
      end
      BOOT_SET: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_n  = FUNCTIONAL;
      end
      FUNCTIONAL: begin
        if (irq_take) begin
          // Interrupt flushes the whole pipe
          kill_o           = '1;
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXCEPTION;
          exc_pc_mux_o     = EXC_PC_IRQ;
          irq_ack_o        = 1'b1;
          irq_id_o         = irq_id_i;
          csr_save_o       = trap_save;
          csr_save_cause_o = 1'b1;
          csr_cause_irq_o  = 1'b1;
          csr_cause_o      = {{(EXC_CODE_W-IRQ_ID_W){1'b0}}, irq_id_i};
        end else if (ev.exception_wb) begin
          // WB keeps its instruction, write enables already suppressed
          kill_o[STAGE_IF]     = 1'b1;
          kill_o[STAGE_ID]     = 1'b1;
          kill_o[STAGE_EX]     = 1'b1;
          pc_set_o             = 1'b1;
          pc_mux_o             = PC_EXCEPTION;
          exc_pc_mux_o         = EXC_PC_EXCEPTION;
          csr_save_o[STAGE_WB] = 1'b1;
          csr_save_cause_o     = 1'b1;
          csr_cause_o          = ev.exc_cause_wb;
        end else if (ev.wfi_wb) begin
          // EX may still drain into WB before sleeping
          halt_o[STAGE_IF] = 1'b1;
          halt_o[STAGE_ID] = 1'b1;
          instr_req_o      = 1'b0;
          state_n          = SLEEP;
        end else if (ev.fencei_wb) begin
          kill_o[STAGE_IF] = 1'b1;
          kill_o[STAGE_ID] = 1'b1;
          kill_o[STAGE_EX] = 1'b1;
          halt_o[STAGE_WB] = 1'b1;
          if (fencei_done_i) begin
            // Flush finished, refetch after the fence.i
            pc_set_o         = 1'b1;
            pc_mux_o         = PC_FENCEI;
            halt_o[STAGE_WB] = 1'b0;
          end else begin
            fencei_start_o = 1'b1;
          end
        end else if (ev.branch_taken_ex) begin
          kill_o[STAGE_IF] = 1'b1;
          kill_o[STAGE_ID] = 1'b1;
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_BRANCH;
          branch_taken_n   = 1'b1;
        end else if (ev.jump_taken_id) begin
          kill_o[STAGE_IF] = 1'b1;
          pc_set_o         = 1'b1;
          pc_mux_o         = ev.mret_id ? PC_MRET : PC_JUMP;
          branch_taken_n   = 1'b1;
        end

        // mret restores CSRs unless WB was flushed
        if (ev.mret_wb && !kill_o[STAGE_WB]) begin
          csr_restore_mret_o = 1'b1;
        end
      end
      SLEEP: begin
        busy_o           = 1'b0;
        instr_req_o      = 1'b0;
        halt_o[STAGE_WB] = 1'b1;
        if (irq_wakeup_i) begin
          state_n = FUNCTIONAL;
        end
      end
      default: begin
        instr_req_o = 1'b0;
        state_n     = RESET;
      end
    endcase

    // New instruction out of IF ends the redirect window
    if (branch_taken_q && if_valid_i && id_ready_i) begin
      branch_taken_n = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q        <= RESET;
      branch_taken_q <= 1'b0;
    end else begin
      state_q        <= state_n;
      branch_taken_q <= branch_taken_n;
    end
  end

  a_save_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(csr_save_o));

endmodule

//--- logic/fencei_handshake.sv
////////////////////////////////////////
// fence.i flush handshake
// Holds the flush request until it is
// acknowledged, then flags completion
////////////////////////////////////////
`timescale 1ns/1ns

module fencei_handshake (
  input  logic clk,
  input  logic rst_n,
  input  logic flush_start_i,
  input  logic fencei_flush_ack_i,
  output logic fencei_flush_req_o,
  output logic done_o,
  output logic ongoing_o
);

  logic req_and_ack_q;

  // Completion is the cycle after request and acknowledge met
  assign done_o    = req_and_ack_q;
  assign ongoing_o = fencei_flush_req_o || req_and_ack_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fencei_flush_req_o <= 1'b0;
      req_and_ack_q      <= 1'b0;
    end else begin
      // Ack only counts while a request is pending
      req_and_ack_q <= fencei_flush_req_o && fencei_flush_ack_i;
      if (fencei_flush_req_o && fencei_flush_ack_i) begin
        fencei_flush_req_o <= 1'b0;
      end else if (flush_start_i) begin
        fencei_flush_req_o <= 1'b1;
      end
    end
  end

  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    (fencei_flush_req_o && !fencei_flush_ack_i) |=> fencei_flush_req_o);

endmodule

//--- logic/ctrl_event_decode.sv
////////////////////////////////////////
// Pipeline event decoder
// Qualifies stage events, picks the WB
// exception cause, gates interrupts
////////////////////////////////////////
`timescale 1ns/1ns

module ctrl_event_decode import ctrl_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_n_i,
  // ID stage
  input  logic          id_instr_valid_i,
  input  logic          id_jump_i,
  input  logic          id_mret_i,
  input  logic          jr_stall_i,
  input  logic          csr_stall_i,
  input  logic          load_stall_i,
  // EX stage
  input  logic          ex_instr_valid_i,
  input  logic          ex_branch_taken_i,
  input  logic          ex_valid_i,
  input  logic          wb_ready_i,
  input  logic          data_req_i,
  // WB stage
  input  logic          wb_instr_valid_i,
  input  logic          wb_lsu_en_i,
  input  logic          wb_instr_fault_i,
  input  logic          wb_instr_bus_err_i,
  input  logic          wb_illegal_i,
  input  logic          wb_ecall_i,
  input  logic          wb_ebreak_i,
  input  logic          wb_wfi_i,
  input  logic          wb_fencei_i,
  input  logic          wb_mret_i,
  input  mpu_status_e   wb_mpu_status_i,
  // From handshake and FSM
  input  logic          fencei_ongoing_i,
  input  logic          branch_taken_q_i,
  ctrl_event_if.decoder ev
);

  logic ex_to_wb;
  logic data_req_q;
  logic wb_fault;

  // EX hands its instruction over to WB
  assign ex_to_wb = ex_valid_i && wb_ready_i;

  // Jumps and mret resolve in ID, blocked once a redirect was taken
  assign ev.jump_taken_id = ((id_jump_i && !jr_stall_i) || (id_mret_i && !csr_stall_i)) &&
                            id_instr_valid_i && !branch_taken_q_i;
  assign ev.mret_id       = id_mret_i && id_instr_valid_i;

  // Branch decision from the EX ALU
  assign ev.branch_taken_ex = ex_branch_taken_i && ex_instr_valid_i && !branch_taken_q_i;

  // Any fault flag on the WB instruction
  assign wb_fault = wb_instr_fault_i || wb_instr_bus_err_i || wb_illegal_i ||
                    wb_ecall_i || wb_ebreak_i || (wb_mpu_status_i != MPU_OK);
  assign ev.exception_wb = wb_fault && wb_instr_valid_i;

  // Cause priority, fetch side first, LSU faults last
  assign ev.exc_cause_wb = wb_instr_fault_i                  ? EXC_CAUSE_INSTR_FAULT     :
                           wb_instr_bus_err_i                ? EXC_CAUSE_INSTR_BUS_FAULT :
                           wb_illegal_i                      ? EXC_CAUSE_ILLEGAL_INSN    :
                           wb_ecall_i                        ? EXC_CAUSE_ECALL_MMODE     :
                           wb_ebreak_i                       ? EXC_CAUSE_BREAKPOINT      :
                           (wb_mpu_status_i == MPU_WR_FAULT) ? EXC_CAUSE_STORE_FAULT     :
                           (wb_mpu_status_i == MPU_RE_FAULT) ? EXC_CAUSE_LOAD_FAULT      :
                           '0;

  // Special instructions in WB
  assign ev.wfi_wb    = wb_wfi_i && wb_instr_valid_i;
  assign ev.fencei_wb = wb_fencei_i && wb_instr_valid_i;
  assign ev.mret_wb   = wb_mret_i && wb_instr_valid_i;

  // Regular ID stalls
  assign ev.stall_id = jr_stall_i || load_stall_i || csr_stall_i;

  // No interrupt while a data access is in flight or fence.i runs
  assign ev.irq_allowed = !(wb_lsu_en_i && wb_instr_valid_i) && !data_req_q &&
                          !fencei_ongoing_i;

  // Data request issued while the LSU instruction is still in EX
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      data_req_q <= 1'b0;
    end else if (data_req_i && !ex_to_wb) begin
      data_req_q <= 1'b1;
    end else if (ex_to_wb) begin
      data_req_q <= 1'b0;
    end
  end

  // A WB exception always carries a real cause code
  a_exc_cause_set: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ev.exception_wb |-> (ev.exc_cause_wb != '0));

endmodule

//--- logic/ctrl_event_if.sv
////////////////////////////////////////
// Pipeline event bundle
// Decoded per-stage events from the
// event decoder to the controller FSM
////////////////////////////////////////
`timescale 1ns/1ns

interface ctrl_event_if import ctrl_pkg::*;;
  // ID stage
  logic      jump_taken_id;
  logic      mret_id;
  // EX stage
  logic      branch_taken_ex;
  // WB stage
  logic      exception_wb;
  exc_code_t exc_cause_wb;
  logic      wfi_wb;
  logic      fencei_wb;
  logic      mret_wb;
  // Back-pressure
  logic      irq_allowed;
  logic      stall_id;

  modport decoder (
    output jump_taken_id, mret_id, branch_taken_ex, exception_wb, exc_cause_wb,
           wfi_wb, fencei_wb, mret_wb, irq_allowed, stall_id
  );

  modport fsm (
    input jump_taken_id, mret_id, branch_taken_ex, exception_wb, exc_cause_wb,
          wfi_wb, fencei_wb, mret_wb, irq_allowed, stall_id
  );
endinterface

//--- logic/ctrl_pkg.sv
////////////////////////////////////////
// Pipeline controller package
// State, PC source and MPU enums, cause
// codes and the widths they are built on
////////////////////////////////////////
package ctrl_pkg;

  // Widths
  localparam int STAGE_N    = 4;
  localparam int EXC_CODE_W = 8;
  localparam int IRQ_ID_W   = 5;

  // Stage bit positions inside a stage mask
  localparam int STAGE_IF = 0;
  localparam int STAGE_ID = 1;
  localparam int STAGE_EX = 2;
  localparam int STAGE_WB = 3;

  typedef logic [STAGE_N-1:0]    stage_mask_t;
  typedef logic [EXC_CODE_W-1:0] exc_code_t;
  typedef logic [IRQ_ID_W-1:0]   irq_id_t;

  // Controller states
  typedef enum logic [1:0] {RESET, BOOT_SET, FUNCTIONAL, SLEEP} ctrl_state_e;

  // Next PC source
  typedef enum logic [2:0] {
    PC_BOOT, PC_JUMP, PC_BRANCH, PC_EXCEPTION, PC_MRET, PC_FENCEI
  } pc_mux_e;

  // Trap target
  typedef enum logic {EXC_PC_EXCEPTION, EXC_PC_IRQ} exc_pc_mux_e;

  // LSU protection check result
  typedef enum logic [1:0] {MPU_OK, MPU_RE_FAULT, MPU_WR_FAULT} mpu_status_e;

  // Synchronous exception causes
  localparam exc_code_t EXC_CAUSE_INSTR_FAULT     = 8'd1;
  localparam exc_code_t EXC_CAUSE_ILLEGAL_INSN    = 8'd2;
  localparam exc_code_t EXC_CAUSE_BREAKPOINT      = 8'd3;
  localparam exc_code_t EXC_CAUSE_LOAD_FAULT      = 8'd5;
  localparam exc_code_t EXC_CAUSE_STORE_FAULT     = 8'd7;
  localparam exc_code_t EXC_CAUSE_ECALL_MMODE     = 8'd11;
  localparam exc_code_t EXC_CAUSE_INSTR_BUS_FAULT = 8'd24;

  // mtvec mode for vectored interrupts
  localparam logic [1:0] MTVEC_VECTORED = 2'b01;

endpackage
